// File: include/tl45_settings.svh
`ifndef TL45_SETTINGS_SVH
`define TL45_SETTINGS_SVH

// bus word and word address widths
`define TL45_DATA_W 32
`define TL45_ADDR_W 30

// top address bits pick the region
`define TL45_PAGE_W 9
`define TL45_RAM_PAGE 9'h000
`define TL45_SYS_PAGE 9'h002

// on-chip ram, 1024 words
`define TL45_RAM_AW 10

// identification word of the system register block
`define TL45_SYS_ID 32'h20191028

`endif

// File: src/tl45_bus_pkg.sv
package tl45_bus_pkg;

`include "tl45_settings.svh"

    // one bus data word
    typedef logic [`TL45_DATA_W-1:0] word_t;

    // word address, byte offset dropped
    typedef logic [`TL45_ADDR_W-1:0] waddr_t;

    // one enable per byte lane
    typedef logic [`TL45_DATA_W/8-1:0] sel_t;

    // which master holds the bus
    typedef enum logic {
        MASTER_A = 1'b0,
        MASTER_B = 1'b1
    } master_t;

endpackage

// File: src/tl45_map_pkg.sv
package tl45_map_pkg;

`include "tl45_settings.svh"

    // destination of a transfer
    typedef enum logic [1:0] {
        REGION_RAM  = 2'd0,
        REGION_SYS  = 2'd2,
        REGION_NONE = 2'd3
    } region_t;

    // system register index, low nibble of the word address
    typedef enum logic [3:0] {
        REG_ID      = 4'd0,
        REG_SCRATCH = 4'd1,
        REG_ERRADDR = 4'd2,
        REG_CYCLES  = 4'd3,
        REG_IRQ     = 4'd4
    } sys_reg_t;

    typedef struct packed {
        logic [`TL45_PAGE_W-1:0]              page;
        logic [`TL45_ADDR_W-`TL45_PAGE_W-1:0] index;
    } ram_view_t;

    typedef struct packed {
        logic [`TL45_PAGE_W-1:0]              page;
        logic [`TL45_ADDR_W-`TL45_PAGE_W-5:0] unused;
        sys_reg_t                             idx;
    } sys_view_t;

    // same address word, read as ram index or as register index
    typedef union packed {
        tl45_bus_pkg::waddr_t word;
        ram_view_t            ram;
        sys_view_t            sys;
    } bus_addr_u;

endpackage

// File: src/tl45_bus_if.sv
`timescale 1ns/10ps

interface tl45_bus_if;

    // arbitrated request
    logic                    cyc;
    logic                    stb;
    logic                    we;
    tl45_map_pkg::bus_addr_u adr;
    tl45_bus_pkg::word_t     dat;
    tl45_bus_pkg::sel_t      sel;
    tl45_bus_pkg::master_t   owner;

    // one of these per accepted strobe
    logic                    ram_stb;
    logic                    sys_stb;
    logic                    none_stb;

    modport decoder (
        output cyc, stb, we, adr, dat, sel, owner,
        output ram_stb, sys_stb, none_stb
    );

    modport target (
        input cyc, stb, we, adr, dat, sel,
        input ram_stb, sys_stb, none_stb
    );

    modport result (
        input cyc, owner, none_stb
    );

endinterface

// File: src/tl45_bus_decode.sv
`timescale 1ns/10ps
`include "tl45_settings.svh"

module tl45_bus_decode (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_a_cyc,
    input  logic                 i_a_stb,
    input  logic                 i_a_we,
    input  tl45_bus_pkg::waddr_t i_a_adr,
    input  tl45_bus_pkg::word_t  i_a_dat,
    input  tl45_bus_pkg::sel_t   i_a_sel,
    input  logic                 i_b_cyc,
    input  logic                 i_b_stb,
    input  logic                 i_b_we,
    input  tl45_bus_pkg::waddr_t i_b_adr,
    input  tl45_bus_pkg::word_t  i_b_dat,
    input  tl45_bus_pkg::sel_t   i_b_sel,
    output logic                 o_a_stall,
    output logic                 o_b_stall,
    tl45_bus_if.decoder          bus
);

    tl45_bus_pkg::master_t   owner_q;
    tl45_bus_pkg::master_t   owner_d;
    logic                    busy;
    logic                    cyc;
    logic                    stb;
    tl45_map_pkg::bus_addr_u adr;
    tl45_map_pkg::region_t   region;

    // holder keeps the bus, A wins when idle
    always_comb begin
        if (busy) begin
            owner_d = owner_q;
        end else if (i_a_cyc) begin
            owner_d = tl45_bus_pkg::MASTER_A;
        end else begin
            owner_d = tl45_bus_pkg::MASTER_B;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy    <= 1'b0;
            owner_q <= tl45_bus_pkg::MASTER_A;
        end else begin
            busy    <= cyc;
            owner_q <= owner_d;
        end
    end

    // owner's request onto the bus
    always_comb begin
        if (owner_d == tl45_bus_pkg::MASTER_A) begin
            cyc      = i_a_cyc;
            stb      = i_a_cyc && i_a_stb;
            adr.word = i_a_adr;
            bus.we   = i_a_we;
            bus.dat  = i_a_dat;
            bus.sel  = i_a_sel;
        end else begin
            cyc      = i_b_cyc;
            stb      = i_b_cyc && i_b_stb;
            adr.word = i_b_adr;
            bus.we   = i_b_we;
            bus.dat  = i_b_dat;
            bus.sel  = i_b_sel;
        end
    end

    // page decode
    always_comb begin
        if (adr.ram.page == `TL45_RAM_PAGE) begin
            region = tl45_map_pkg::REGION_RAM;
        end else if (adr.ram.page == `TL45_SYS_PAGE) begin
            region = tl45_map_pkg::REGION_SYS;
        end else begin
            region = tl45_map_pkg::REGION_NONE;
        end
    end

    assign bus.cyc      = cyc;
    assign bus.stb      = stb;
    assign bus.adr      = adr;
    assign bus.owner    = owner_d;
    assign bus.ram_stb  = stb && (region == tl45_map_pkg::REGION_RAM);
    assign bus.sys_stb  = stb && (region == tl45_map_pkg::REGION_SYS);
    assign bus.none_stb = stb && (region == tl45_map_pkg::REGION_NONE);

    // only the master without the grant waits
    assign o_a_stall = (owner_d != tl45_bus_pkg::MASTER_A);
    assign o_b_stall = (owner_d != tl45_bus_pkg::MASTER_B);

endmodule

// File: src/tl45_block_ram.sv
`timescale 1ns/10ps
`include "tl45_settings.svh"

module tl45_block_ram (
    input  logic                i_clk,
    tl45_bus_if.target          bus,
    output logic                o_ack,
    output tl45_bus_pkg::word_t o_data
);

    localparam int DEPTH = 1 << `TL45_RAM_AW;
    localparam int LANES = `TL45_DATA_W / 8;

    tl45_bus_pkg::word_t     mem [DEPTH];
    logic [`TL45_RAM_AW-1:0] idx;

    // low bits of the page offset address the array
    assign idx = bus.adr.ram.index[`TL45_RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (bus.ram_stb && bus.we) begin
            for (int i = 0; i < LANES; i++) begin
                if (bus.sel[i]) begin
                    mem[idx][8*i +: 8] <= bus.dat[8*i +: 8];
                end
            end
        end
    end

    // read returns the word before any write in the same cycle
    always_ff @(posedge i_clk) begin
        if (bus.ram_stb) begin
            o_data <= mem[idx];
        end
    end

    always_ff @(posedge i_clk) begin
        o_ack <= bus.ram_stb;
    end

endmodule

// File: src/tl45_sys_regs.sv
`timescale 1ns/10ps
`include "tl45_settings.svh"

module tl45_sys_regs (
    input  logic                i_clk,
    input  logic                i_reset,
    tl45_bus_if.target          bus,
    output logic                o_ack,
    output tl45_bus_pkg::word_t o_data,
    output logic                o_irq
);

    localparam int TOP = `TL45_DATA_W - 1;

    tl45_bus_pkg::word_t    scratch;
    tl45_bus_pkg::word_t    cycles;
    tl45_bus_pkg::waddr_t   err_addr;
    logic                   irq;
    tl45_map_pkg::sys_reg_t idx;

    assign idx   = bus.adr.sys.idx;
    assign o_irq = irq;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= bus.sys_stb;
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.sys_stb && bus.we && (idx == tl45_map_pkg::REG_SCRATCH)) begin
            scratch <= bus.dat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            irq <= 1'b0;
        end else if (bus.sys_stb && bus.we && (idx == tl45_map_pkg::REG_IRQ)) begin
            irq <= bus.dat[0];
        end
    end

    // top bit sticks once reached, the rest keeps wrapping
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cycles <= '0;
        end else if (!cycles[TOP]) begin
            cycles <= cycles + 1'b1;
        end else begin
            cycles[TOP-1:0] <= cycles[TOP-1:0] + 1'b1;
        end
    end

    // address of the last access to an unmapped page
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_addr <= '0;
        end else if (bus.none_stb) begin
            err_addr <= bus.adr.word;
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.sys_stb) begin
            case (idx)
                tl45_map_pkg::REG_ID:      o_data <= `TL45_SYS_ID;
                tl45_map_pkg::REG_SCRATCH: o_data <= scratch;
                tl45_map_pkg::REG_ERRADDR: o_data <= {err_addr, 2'b00};
                tl45_map_pkg::REG_CYCLES:  o_data <= cycles;
                tl45_map_pkg::REG_IRQ:     o_data <= {{TOP{1'b0}}, irq};
                default:                   o_data <= '0;
            endcase
        end
    end

endmodule

// File: src/tl45_bus_response.sv
`timescale 1ns/10ps

module tl45_bus_response (
    input  logic                i_clk,
    input  logic                i_reset,
    tl45_bus_if.result          bus,
    input  logic                i_ram_ack,
    input  tl45_bus_pkg::word_t i_ram_data,
    input  logic                i_sys_ack,
    input  tl45_bus_pkg::word_t i_sys_data,
    output logic                o_a_ack,
    output logic                o_a_err,
    output tl45_bus_pkg::word_t o_a_data,
    output logic                o_b_ack,
    output logic                o_b_err,
    output tl45_bus_pkg::word_t o_b_data
);

    tl45_bus_pkg::master_t owner_p;
    logic                  err_p;
    logic                  ack_any;
    logic                  held;
    logic                  to_a;
    logic                  to_b;
    tl45_bus_pkg::word_t   rdata;

    // owner and error of the transfer now in the target stage
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_p   <= 1'b0;
            owner_p <= tl45_bus_pkg::MASTER_A;
        end else begin
            err_p   <= bus.none_stb;
            owner_p <= bus.owner;
        end
    end

    assign ack_any = i_ram_ack || i_sys_ack;
    assign rdata   = i_ram_ack ? i_ram_data : (i_sys_ack ? i_sys_data : '0);

    // drop the answer if its master gave up the bus
    assign held = bus.cyc && (bus.owner == owner_p);
    assign to_a = held && (owner_p == tl45_bus_pkg::MASTER_A);
    assign to_b = held && (owner_p == tl45_bus_pkg::MASTER_B);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_a_ack  <= 1'b0;
            o_a_err  <= 1'b0;
            o_a_data <= '0;
            o_b_ack  <= 1'b0;
            o_b_err  <= 1'b0;
            o_b_data <= '0;
        end else begin
            o_a_ack  <= to_a && ack_any;
            o_a_err  <= to_a && err_p;
            o_a_data <= (to_a && ack_any) ? rdata : '0;
            o_b_ack  <= to_b && ack_any;
            o_b_err  <= to_b && err_p;
            o_b_data <= (to_b && ack_any) ? rdata : '0;
        end
    end

endmodule

// File: src/tl45_bus_top.sv
`timescale 1ns/10ps

module tl45_bus_top (
    input  logic                 i_clk,
    input  logic                 i_reset,
    // master A, data port
    input  logic                 i_a_cyc,
    input  logic                 i_a_stb,
    input  logic                 i_a_we,
    input  tl45_bus_pkg::waddr_t i_a_adr,
    input  tl45_bus_pkg::word_t  i_a_dat,
    input  tl45_bus_pkg::sel_t   i_a_sel,
    output logic                 o_a_ack,
    output logic                 o_a_err,
    output logic                 o_a_stall,
    output tl45_bus_pkg::word_t  o_a_data,
    // master B, instruction port
    input  logic                 i_b_cyc,
    input  logic                 i_b_stb,
    input  logic                 i_b_we,
    input  tl45_bus_pkg::waddr_t i_b_adr,
    input  tl45_bus_pkg::word_t  i_b_dat,
    input  tl45_bus_pkg::sel_t   i_b_sel,
    output logic                 o_b_ack,
    output logic                 o_b_err,
    output logic                 o_b_stall,
    output tl45_bus_pkg::word_t  o_b_data,
    output logic                 o_irq
);

    logic                ram_ack;
    tl45_bus_pkg::word_t ram_data;
    logic                sys_ack;
    tl45_bus_pkg::word_t sys_data;

    tl45_bus_if bus ();

    tl45_bus_decode decode_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_a_cyc(i_a_cyc), .i_a_stb(i_a_stb), .i_a_we(i_a_we),
        .i_a_adr(i_a_adr), .i_a_dat(i_a_dat), .i_a_sel(i_a_sel),
        .i_b_cyc(i_b_cyc), .i_b_stb(i_b_stb), .i_b_we(i_b_we),
        .i_b_adr(i_b_adr), .i_b_dat(i_b_dat), .i_b_sel(i_b_sel),
        .o_a_stall(o_a_stall), .o_b_stall(o_b_stall),
        .bus(bus.decoder)
    );

    tl45_block_ram ram_i (
        .i_clk(i_clk), .bus(bus.target),
        .o_ack(ram_ack), .o_data(ram_data)
    );

    tl45_sys_regs sys_i (
        .i_clk(i_clk), .i_reset(i_reset), .bus(bus.target),
        .o_ack(sys_ack), .o_data(sys_data), .o_irq(o_irq)
    );

    tl45_bus_response response_i (
        .i_clk(i_clk), .i_reset(i_reset), .bus(bus.result),
        .i_ram_ack(ram_ack), .i_ram_data(ram_data),
        .i_sys_ack(sys_ack), .i_sys_data(sys_data),
        .o_a_ack(o_a_ack), .o_a_err(o_a_err), .o_a_data(o_a_data),
        .o_b_ack(o_b_ack), .o_b_err(o_b_err), .o_b_data(o_b_data)
    );

endmodule

// File: bench/tl45_bus_sva.sv
`timescale 1ns/10ps

module tl45_bus_sva (
    input logic i_clk,
    input logic i_reset,
    input logic i_a_cyc,
    input logic i_b_cyc,
    input logic i_a_stall,
    input logic i_b_stall,
    input logic i_a_ack,
    input logic i_a_err,
    input logic i_b_ack,
    input logic i_b_err
);

    logic held;

    // some master has cyc and the grant in this cycle
    assign held = (i_a_cyc && !i_a_stall) || (i_b_cyc && !i_b_stall);

    // one answer kind per transfer
    no_ack_and_err: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_a_ack && i_a_err) && !(i_b_ack && i_b_err))
        else $error("ack and err raised together");

    // answers only go to a master that still holds cyc
    ack_needs_cyc_a: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_a_ack || i_a_err) |-> i_a_cyc)
        else $error("answer given to master A without cyc");

    ack_needs_cyc_b: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_b_ack || i_b_err) |-> i_b_cyc)
        else $error("answer given to master B without cyc");

    // two requesters on an idle bus, A wins and B waits
    one_grant: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_a_cyc && i_b_cyc && !$past(held)) |-> (!i_a_stall && i_b_stall))
        else $error("contested idle bus not granted to master A alone");

    // granted master keeps the bus while cyc stays high
    owner_not_stalled_a: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_a_cyc && $past(i_a_cyc && !i_a_stall)) |-> !i_a_stall)
        else $error("bus owner A sees stall");

    owner_not_stalled_b: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_b_cyc && $past(i_b_cyc && !i_b_stall)) |-> !i_b_stall)
        else $error("bus owner B sees stall");

endmodule

bind tl45_bus_top tl45_bus_sva sva_i (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_a_cyc(i_a_cyc), .i_b_cyc(i_b_cyc),
    .i_a_stall(o_a_stall), .i_b_stall(o_b_stall),
    .i_a_ack(o_a_ack), .i_a_err(o_a_err),
    .i_b_ack(o_b_ack), .i_b_err(o_b_err)
);

// File: bench/tl45_bus_tb.sv
`timescale 1ns/10ps
`include "tl45_settings.svh"

module tl45_bus_tb;

    localparam int TIMEOUT_CYCLES = 50;

    // one expected answer, kept in bus order
    typedef struct packed {
        logic                master;
        logic                err;
        logic                check_data;
        logic [31:0]         due;
        tl45_bus_pkg::word_t data;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic [1:0]           m_cyc;
    logic [1:0]           m_stb;
    logic [1:0]           m_we;
    tl45_bus_pkg::waddr_t m_adr [2];
    tl45_bus_pkg::word_t  m_dat [2];
    tl45_bus_pkg::sel_t   m_sel [2];
    wire  [1:0]           m_ack;
    wire  [1:0]           m_err;
    wire  [1:0]           m_stall;
    wire  [31:0]          m_data [2];
    wire                  irq;

    expect_t              expected [$];
    int                   pending [2];
    int                   stall_wait [2];
    logic [31:0]          cycle;
    logic [31:0]          lcg_state;
    logic [31:0]          last_data;
    string                test_name;

    // reference model state
    tl45_bus_pkg::word_t  ref_mem [1 << `TL45_RAM_AW];
    tl45_bus_pkg::word_t  ref_scratch;
    tl45_bus_pkg::waddr_t ref_erraddr;
    logic                 ref_irq;

    tl45_bus_top dut_i (
        .i_clk(clk), .i_reset(reset),
        .i_a_cyc(m_cyc[0]), .i_a_stb(m_stb[0]), .i_a_we(m_we[0]),
        .i_a_adr(m_adr[0]), .i_a_dat(m_dat[0]), .i_a_sel(m_sel[0]),
        .o_a_ack(m_ack[0]), .o_a_err(m_err[0]), .o_a_stall(m_stall[0]), .o_a_data(m_data[0]),
        .i_b_cyc(m_cyc[1]), .i_b_stb(m_stb[1]), .i_b_we(m_we[1]),
        .i_b_adr(m_adr[1]), .i_b_dat(m_dat[1]), .i_b_sel(m_sel[1]),
        .o_b_ack(m_ack[1]), .o_b_err(m_err[1]), .o_b_stall(m_stall[1]), .o_b_data(m_data[1]),
        .o_irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // spread over the whole ram index range
    function automatic tl45_bus_pkg::waddr_t ram_addr(input int i);
        return tl45_bus_pkg::waddr_t'({i[5:0], 4'd3});
    endfunction

    function automatic tl45_bus_pkg::waddr_t sys_addr(input int idx);
        return {`TL45_SYS_PAGE, {(`TL45_ADDR_W - `TL45_PAGE_W - 4){1'b0}}, idx[3:0]};
    endfunction

    function automatic tl45_bus_pkg::word_t fill_word(input int i);
        return {16'hC3A5 ^ i[15:0], i[15:0] * 16'd7};
    endfunction

    // applies one transfer to the model and returns the expected read word
    function automatic tl45_bus_pkg::word_t model_access(input logic we,
            input tl45_bus_pkg::waddr_t adr, input tl45_bus_pkg::word_t dat,
            input tl45_bus_pkg::sel_t sel, output logic err);
        tl45_bus_pkg::word_t     rd;
        logic [`TL45_PAGE_W-1:0] page;
        logic [`TL45_RAM_AW-1:0] idx;
        page = adr[`TL45_ADDR_W-1 -: `TL45_PAGE_W];
        idx  = adr[`TL45_RAM_AW-1:0];
        rd   = '0;
        err  = 1'b0;
        if (page == `TL45_RAM_PAGE) begin
            rd = ref_mem[idx];
            for (int i = 0; i < 4; i++) begin
                if (we && sel[i]) begin
                    ref_mem[idx][8*i +: 8] = dat[8*i +: 8];
                end
            end
        end else if (page == `TL45_SYS_PAGE) begin
            case (adr[3:0])
                4'd0:    rd = `TL45_SYS_ID;
                4'd1:    rd = ref_scratch;
                4'd2:    rd = 32'(ref_erraddr) * 32'd4;
                4'd4:    rd = {31'd0, ref_irq};
                default: rd = '0;
            endcase
            if (we && adr[3:0] == 4'd1) begin
                ref_scratch = dat;
            end
            if (we && adr[3:0] == 4'd4) begin
                ref_irq = dat[0];
            end
        end else begin
            err         = 1'b1;
            ref_erraddr = adr;
        end
        return rd;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
                                     test_name, name, exp, act));
        end
    endtask

    // holds one strobe until the arbiter takes it, then records the answer
    task automatic issue_strobe(input int m, input logic we, input tl45_bus_pkg::waddr_t adr,
                                input tl45_bus_pkg::word_t dat, input tl45_bus_pkg::sel_t sel);
        expect_t e;
        logic    err;
        int      n;
        m_cyc[m] = 1'b1;
        m_stb[m] = 1'b1;
        m_we[m]  = we;
        m_adr[m] = adr;
        m_dat[m] = dat;
        m_sel[m] = sel;
        n = 0;
        @(negedge clk);
        while (m_stall[m]) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_failure("strobe never accepted, stall stayed high");
            end
            @(negedge clk);
        end
        stall_wait[m] = n;
        e.master      = m[0];
        e.data        = model_access(we, adr, dat, sel, err);
        e.err         = err;
        // cycle counter value is checked by the test itself
        e.check_data  = !we && !err && (adr != sys_addr(3));
        e.due         = cycle + 32'd2;
        expected.push_back(e);
        pending[m]++;
        @(posedge clk);
        #1;
        m_stb[m] = 1'b0;
    endtask

    // waits for all answers of a master, drops cyc, then one idle cycle
    task automatic end_cycle(input int m);
        int n;
        n = 0;
        while (pending[m] != 0) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_failure("answer missing after timeout");
            end
            @(posedge clk);
        end
        #1;
        m_cyc[m] = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // every ack or err against the oldest expected answer
    always @(negedge clk) begin
        expect_t e;
        if (!reset) begin
            for (int m = 0; m < 2; m++) begin
                if (m_ack[m] || m_err[m]) begin
                    if (expected.size() == 0) begin
                        report_failure($sformatf("master %0d answered with nothing pending", m));
                    end
                    e = expected.pop_front();
                    check_value("owner", 32'(e.master), 32'(m));
                    check_value("err", 32'(e.err), 32'(m_err[m]));
                    check_value("ack", 32'(!e.err), 32'(m_ack[m]));
                    check_value("latency", e.due, cycle);
                    if (e.check_data) begin
                        check_value("read data", e.data, m_data[m]);
                    end
                    last_data = m_data[m];
                    pending[m]--;
                end else begin
                    check_value("data without ack", '0, m_data[m]);
                end
            end
        end
    end

    initial begin
        logic [31:0]          r;
        logic [31:0]          first;
        tl45_bus_pkg::waddr_t bad;
        lcg_state = 32'd2708;
        cycle     = '0;
        reset     = 1'b1;
        m_cyc     = '0;
        m_stb     = '0;
        m_we      = '0;
        ref_irq   = 1'b0;
        ref_erraddr = '0;
        for (int m = 0; m < 2; m++) begin
            m_adr[m]   = '0;
            m_dat[m]   = '0;
            m_sel[m]   = '0;
            pending[m] = 0;
        end
        repeat (3) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        test_name = "cycles";
        issue_strobe(0, 1'b0, sys_addr(3), '0, 4'hf);
        end_cycle(0);
        first = last_data;
        check_value("first read below 100", 32'd1, 32'(first < 32'd100));

        test_name = "ram";
        for (int i = 0; i < 64; i++) begin
            issue_strobe(0, 1'b1, ram_addr(i), fill_word(i), 4'hf);
        end
        end_cycle(0);
        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            issue_strobe(0, 1'b1, ram_addr(int'(r[5:0])), lcg_next(), r[11:8]);
        end
        end_cycle(0);
        for (int i = 0; i < 64; i++) begin
            issue_strobe(0, 1'b0, ram_addr(i), '0, 4'hf);
        end
        end_cycle(0);

        test_name = "sys";
        issue_strobe(0, 1'b0, sys_addr(0), '0, 4'hf);
        issue_strobe(0, 1'b1, sys_addr(1), lcg_next(), 4'hf);
        issue_strobe(0, 1'b0, sys_addr(1), '0, 4'hf);
        issue_strobe(0, 1'b1, sys_addr(4), 32'h0000_0001, 4'hf);
        issue_strobe(0, 1'b0, sys_addr(4), '0, 4'hf);
        issue_strobe(0, 1'b1, sys_addr(0), 32'hFFFF_FFFF, 4'hf);
        issue_strobe(0, 1'b0, sys_addr(0), '0, 4'hf);
        end_cycle(0);
        check_value("o_irq", 32'd1, 32'(irq));

        test_name = "unmapped";
        r   = lcg_next();
        bad = {9'h100 | 9'(r[7:0]), r[20:0]};
        issue_strobe(0, 1'b0, bad, '0, 4'hf);
        issue_strobe(0, 1'b0, sys_addr(2), '0, 4'hf);
        end_cycle(0);

        // both masters raise cyc in the same cycle
        test_name = "arbitration";
        fork
            begin
                issue_strobe(0, 1'b0, ram_addr(1), '0, 4'hf);
                issue_strobe(0, 1'b0, ram_addr(2), '0, 4'hf);
                end_cycle(0);
            end
            begin
                issue_strobe(1, 1'b0, ram_addr(3), '0, 4'hf);
                end_cycle(1);
            end
        join
        check_value("b stalled behind a", 32'd1, 32'(stall_wait[1] > 0));

        test_name = "cycles";
        issue_strobe(0, 1'b0, sys_addr(3), '0, 4'hf);
        end_cycle(0);
        check_value("second read larger", 32'd1, 32'(last_data > first));

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
src/tl45_bus_pkg.sv
src/tl45_map_pkg.sv
src/tl45_bus_if.sv
src/tl45_bus_decode.sv
src/tl45_block_ram.sv
src/tl45_sys_regs.sv
src/tl45_bus_response.sv
src/tl45_bus_top.sv
bench/tl45_bus_sva.sv
bench/tl45_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tl45_bus_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
